/* hw/stream_burst_pkg.sv */
package stream_burst_pkg;

  // Stream word width, fixed by the 32-bit register map.
  localparam int unsigned data_w = 32;

  typedef logic [data_w-1:0] word_t;
  typedef logic [31:0]       stat_t;
  typedef logic [4:0]        lite_addr_t;
  typedef logic [1:0]        resp_t;

  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // Control register, bit 0 enables the sink.
  localparam lite_addr_t reg_ctrl = 5'h00;

  // Read-only statistics.
  localparam lite_addr_t reg_packets  = 5'h04; // Bursts completed.
  localparam lite_addr_t reg_words    = 5'h08; // Words accepted.
  localparam lite_addr_t reg_sum      = 5'h0C; // Sum of words, mod 2^32.
  localparam lite_addr_t reg_last_len = 5'h10; // Length of last burst.
  localparam lite_addr_t reg_seq_err  = 5'h14; // Out-of-sequence words.

  // Source FSM.
  typedef enum logic [1:0] {
    src_idle,
    src_wait,
    src_send
  } src_state_e;

endpackage

/* hw/burst_source.sv */
`timescale 1ns/1ps

module burst_source import stream_burst_pkg::*; #(
  parameter int unsigned START_COUNT = 32,
  parameter int unsigned BURST_LEN   = 8
) (
  input  logic  M_AXIS_ACLK,
  input  logic  M_AXIS_ARESETN,
  output logic  tvalid,
  output word_t tdata,
  output logic  tlast,
  input  logic  tready
);

  localparam int unsigned wait_w = $clog2(START_COUNT + 1);
  localparam int unsigned idx_w  = $clog2(BURST_LEN + 1);

  src_state_e        state;
  logic [wait_w-1:0] wait_cnt;
  logic [idx_w-1:0]  idx;
  logic [idx_w-1:0]  idx_next;
  logic              wait_done;
  logic              beat;

  assign beat      = tvalid && tready; // Completed handshake.
  assign idx_next  = idx + 1'b1;
  assign wait_done = (state == src_wait) && (wait_cnt == wait_w'(START_COUNT - 1));

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state    <= src_idle;
      wait_cnt <= '0;
      idx      <= '0;
      tvalid   <= 1'b0;
    end else begin
      case (state)
        src_idle: begin
          wait_cnt <= '0;
          state    <= src_wait;
        end
        src_wait: begin
          if (wait_done) begin
            idx    <= idx_w'(1);
            tvalid <= 1'b1;
            state  <= src_send;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        src_send: begin
          // Hold the beat until the sink side takes it.
          if (beat) begin
            if (tlast) begin
              tvalid <= 1'b0;
              state  <= src_idle;
            end else begin
              idx <= idx_next;
            end
          end
        end
        default: begin
          tvalid <= 1'b0;
          state  <= src_idle;
        end
      endcase
    end
  end

  // Word value is the burst index.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (wait_done) begin
      tdata <= word_t'(1);
      tlast <= (BURST_LEN == 1);
    end else if (beat && !tlast) begin
      tdata <= word_t'(idx_next);
      tlast <= (idx_next == idx_w'(BURST_LEN)); // Final word of the burst.
    end
  end

endmodule

/* hw/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo import stream_burst_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic  M_AXIS_ACLK,
  input  logic  M_AXIS_ARESETN,
  input  logic  s_tvalid,
  input  word_t s_tdata,
  input  logic  s_tlast,
  output logic  s_tready,
  output logic  m_tvalid,
  output word_t m_tdata,
  output logic  m_tlast,
  input  logic  m_tready
);

  localparam int unsigned ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned cnt_w = $clog2(DEPTH + 1);

  word_t            mem_data [DEPTH];
  logic             mem_last [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(DEPTH - 1)) ? '0 : ptr + 1'b1; // Wraps for any depth.
  endfunction

  assign s_tready = (count != cnt_w'(DEPTH));
  assign m_tvalid = (count != '0);
  assign m_tdata  = mem_data[rd_ptr];
  assign m_tlast  = mem_last[rd_ptr];

  assign push = s_tvalid && s_tready;
  assign pop  = m_tvalid && m_tready;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (push) begin
      mem_data[wr_ptr] <= s_tdata;
      mem_last[wr_ptr] <= s_tlast;
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      // Simultaneous push and pop leaves the count alone.
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hw/burst_sink.sv */
`timescale 1ns/1ps

module burst_sink import stream_burst_pkg::*; #(
  parameter int unsigned BURST_LEN = 8
) (
  input  logic       M_AXIS_ACLK,
  input  logic       M_AXIS_ARESETN,
  input  logic       tvalid,
  input  word_t      tdata,
  input  logic       tlast,
  output logic       tready,
  input  logic       awvalid,
  output logic       awready,
  input  lite_addr_t awaddr,
  input  logic       wvalid,
  output logic       wready,
  input  word_t      wdata,
  output logic       bvalid,
  input  logic       bready,
  output resp_t      bresp,
  input  logic       arvalid,
  output logic       arready,
  input  lite_addr_t araddr,
  output logic       rvalid,
  input  logic       rready,
  output word_t      rdata,
  output resp_t      rresp
);

  // Headroom above BURST_LEN so an overlong burst still shows up.
  localparam int unsigned len_w = $clog2(BURST_LEN + 1) + 1;

  logic             sink_enable;
  logic             beat;
  word_t            expected;
  logic [len_w-1:0] run_len;
  logic [len_w-1:0] len_next;
  stat_t            packets;
  stat_t            words;
  stat_t            sum;
  stat_t            last_len;
  stat_t            seq_err;
  logic             aw_held;
  logic             w_held;
  lite_addr_t       aw_addr_q;
  word_t            w_data_q;
  word_t            rd_word;
  resp_t            rd_resp;

  assign tready   = sink_enable;
  assign beat     = tvalid && tready;
  assign len_next = (run_len == '1) ? run_len : run_len + 1'b1; // Saturates.

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      expected <= word_t'(1);
      run_len  <= '0;
      packets  <= '0;
      words    <= '0;
      sum      <= '0;
      last_len <= '0;
      seq_err  <= '0;
    end else if (beat) begin
      words <= words + 1'b1;
      sum   <= sum + stat_t'(tdata);
      if (tdata != expected) seq_err <= seq_err + 1'b1;
      if (tlast) begin
        packets  <= packets + 1'b1;
        last_len <= stat_t'(len_next);
        run_len  <= '0;
        expected <= word_t'(1); // Next burst restarts at 1.
      end else begin
        run_len  <= len_next;
        expected <= tdata + 1'b1;
      end
    end
  end

  // Write address and data are taken independently, then committed together.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      awready     <= 1'b0;
      wready      <= 1'b0;
      aw_held     <= 1'b0;
      w_held      <= 1'b0;
      bvalid      <= 1'b0;
      bresp       <= resp_okay;
      sink_enable <= 1'b0;
    end else begin
      awready <= awvalid && !awready && !aw_held && !bvalid;
      wready  <= wvalid && !wready && !w_held && !bvalid;
      if (awvalid && awready) aw_held <= 1'b1;
      if (wvalid && wready) w_held <= 1'b1;
      if (aw_held && w_held && !bvalid) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        bvalid  <= 1'b1;
        if (aw_addr_q == reg_ctrl) begin
          sink_enable <= w_data_q[0];
          bresp       <= resp_okay;
        end else begin
          bresp <= resp_slverr; // Read-only or unmapped.
        end
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (awvalid && awready) aw_addr_q <= awaddr;
    if (wvalid && wready) w_data_q <= wdata;
  end

  always_comb begin
    rd_word = '0;
    rd_resp = resp_okay;
    case (araddr)
      reg_ctrl:     rd_word = word_t'(sink_enable);
      reg_packets:  rd_word = packets;
      reg_words:    rd_word = words;
      reg_sum:      rd_word = sum;
      reg_last_len: rd_word = last_len;
      reg_seq_err:  rd_word = seq_err;
      default:      rd_resp = resp_slverr;
    endcase
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (arvalid && arready) begin
        rvalid <= 1'b1;
        rdata  <= rd_word;
        rresp  <= rd_resp;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

/* hw/stream_burst_top.sv */
`timescale 1ns/1ps

module stream_burst_top import stream_burst_pkg::*; #(
  parameter int unsigned START_COUNT = 32,
  parameter int unsigned BURST_LEN   = 8,
  parameter int unsigned FIFO_DEPTH  = 4
) (
  input  logic       M_AXIS_ACLK,
  input  logic       M_AXIS_ARESETN,
  input  logic       awvalid,
  output logic       awready,
  input  lite_addr_t awaddr,
  input  logic       wvalid,
  output logic       wready,
  input  word_t      wdata,
  output logic       bvalid,
  input  logic       bready,
  output resp_t      bresp,
  input  logic       arvalid,
  output logic       arready,
  input  lite_addr_t araddr,
  output logic       rvalid,
  input  logic       rready,
  output word_t      rdata,
  output resp_t      rresp
);

  logic  src_tvalid;
  word_t src_tdata;
  logic  src_tlast;
  logic  src_tready;
  logic  snk_tvalid;
  word_t snk_tdata;
  logic  snk_tlast;
  logic  snk_tready;

  burst_source #(
    .START_COUNT(START_COUNT),
    .BURST_LEN  (BURST_LEN)
  ) i_source (
    .M_AXIS_ACLK   (M_AXIS_ACLK),
    .M_AXIS_ARESETN(M_AXIS_ARESETN),
    .tvalid        (src_tvalid),
    .tdata         (src_tdata),
    .tlast         (src_tlast),
    .tready        (src_tready)
  );

  stream_fifo #(
    .DEPTH(FIFO_DEPTH)
  ) i_fifo (
    .M_AXIS_ACLK   (M_AXIS_ACLK),
    .M_AXIS_ARESETN(M_AXIS_ARESETN),
    .s_tvalid      (src_tvalid),
    .s_tdata       (src_tdata),
    .s_tlast       (src_tlast),
    .s_tready      (src_tready),
    .m_tvalid      (snk_tvalid),
    .m_tdata       (snk_tdata),
    .m_tlast       (snk_tlast),
    .m_tready      (snk_tready)
  );

  burst_sink #(
    .BURST_LEN(BURST_LEN)
  ) i_sink (
    .M_AXIS_ACLK   (M_AXIS_ACLK),
    .M_AXIS_ARESETN(M_AXIS_ARESETN),
    .tvalid        (snk_tvalid),
    .tdata         (snk_tdata),
    .tlast         (snk_tlast),
    .tready        (snk_tready),
    .awvalid       (awvalid),
    .awready       (awready),
    .awaddr        (awaddr),
    .wvalid        (wvalid),
    .wready        (wready),
    .wdata         (wdata),
    .bvalid        (bvalid),
    .bready        (bready),
    .bresp         (bresp),
    .arvalid       (arvalid),
    .arready       (arready),
    .araddr        (araddr),
    .rvalid        (rvalid),
    .rready        (rready),
    .rdata         (rdata),
    .rresp         (rresp)
  );

endmodule

/* tests/stream_burst_assertions.sv */
`timescale 1ns/1ps

module stream_burst_assertions import stream_burst_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input logic  M_AXIS_ACLK,
  input logic  M_AXIS_ARESETN,
  input logic  s_tvalid,
  input logic  s_tready,
  input logic  m_tvalid,
  input word_t m_tdata,
  input logic  m_tlast,
  input logic  m_tready
);

  int unsigned violations = 0; // Failed assertions so far.
  int          level;          // Words held, counted from both handshakes.

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      level <= 0;
    end else begin
      level <= level + int'(s_tvalid && s_tready) - int'(m_tvalid && m_tready);
    end
  end

  // A stalled beat keeps its contents.
  stall_stable: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
    else begin
      $error("FIFO output changed while the beat was stalled");
      violations++;
    end

  empty_no_valid: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    level == 0 |-> !m_tvalid)
    else begin
      $error("FIFO drives m_tvalid while empty");
      violations++;
    end

  full_no_ready: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    level == int'(DEPTH) |-> !s_tready)
    else begin
      $error("FIFO drives s_tready while full");
      violations++;
    end

endmodule

/* tests/tb_stream_burst.sv */
`timescale 1ns/1ps

module tb_stream_burst
  import stream_burst_pkg::*;
();

  localparam int unsigned start_count = 32;
  localparam int unsigned burst_len   = 8;
  localparam int unsigned fifo_depth  = 4;
  localparam int unsigned rst_cycles  = 16;
  localparam int unsigned full_sum    = burst_len * (burst_len + 1) / 2; // 1 + 2 + ... + 8.
  // Cycle budget of each test.
  localparam int unsigned budget_reset = start_count + 100;
  localparam int unsigned budget_ctrl  = 100;
  localparam int unsigned budget_acct  = 350;
  localparam int unsigned budget_len   = 20 * (start_count + burst_len + fifo_depth);
  localparam int unsigned budget_order = 12 * 120 + 50;
  localparam int unsigned total_budget = rst_cycles + budget_reset + budget_ctrl
                                         + budget_acct + budget_len + budget_order;

  logic       M_AXIS_ACLK = 1'b0;
  logic       M_AXIS_ARESETN;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rvalid, rready;
  lite_addr_t awaddr, araddr;
  word_t      wdata, rdata;
  resp_t      bresp, rresp;

  stream_burst_top #(
    .START_COUNT(start_count),
    .BURST_LEN  (burst_len),
    .FIFO_DEPTH (fifo_depth)
  ) i_dut (.*);

  bind stream_fifo stream_burst_assertions #(.DEPTH(DEPTH)) i_fifo_checks (.*);

  always #20 M_AXIS_ACLK = ~M_AXIS_ACLK; // 40 ns period.

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first failed check.");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      stop_on_error($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp)
      stop_on_error($sformatf("[ERROR] %s resp: got 0x%01h, expected 0x%01h", name, got, exp));
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(negedge M_AXIS_ACLK);
  endtask

  // Address and data go out together; each drops after its own handshake.
  task automatic lite_write(input lite_addr_t addr, input word_t data, output resp_t resp);
    logic aw_hit;
    logic w_hit;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (awvalid || wvalid) begin
      aw_hit = awvalid && awready;
      w_hit  = wvalid && wready;
      @(negedge M_AXIS_ACLK);
      if (aw_hit) awvalid = 1'b0;
      if (w_hit) wvalid = 1'b0;
    end
    while (!bvalid) @(negedge M_AXIS_ACLK);
    resp = bresp;
    @(negedge M_AXIS_ACLK);
    bready = 1'b0;
  endtask

  task automatic lite_read(input lite_addr_t addr, output word_t data, output resp_t resp);
    logic ar_hit;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (arvalid) begin
      ar_hit = arready;
      @(negedge M_AXIS_ACLK);
      if (ar_hit) arvalid = 1'b0;
    end
    while (!rvalid) @(negedge M_AXIS_ACLK);
    data = rdata;
    resp = rresp;
    @(negedge M_AXIS_ACLK);
    rready = 1'b0;
  endtask

  task automatic write_reg(input string name, input lite_addr_t addr, input word_t data,
                           input resp_t exp_resp);
    resp_t resp;
    lite_write(addr, data, resp);
    check_resp(name, resp, exp_resp);
  endtask

  task automatic read_reg(input string name, input lite_addr_t addr, output word_t data);
    resp_t resp;
    lite_read(addr, data, resp);
    check_resp(name, resp, resp_okay);
  endtask

  task automatic expect_reg(input string name, input lite_addr_t addr, input word_t exp);
    word_t data;
    read_reg(name, addr, data);
    check_word(name, data, exp);
  endtask

  // Counters frozen: W = 8P + k, and the sum is P full bursts plus 1..k.
  task automatic check_accounting();
    word_t packets, words, sum, k;
    read_reg("reg_packets", reg_packets, packets);
    read_reg("reg_words", reg_words, words);
    read_reg("reg_sum", reg_sum, sum);
    if (words < word_t'(burst_len) * packets)
      stop_on_error("Fewer words accepted than the completed packets need.");
    k = words - word_t'(burst_len) * packets;
    if (k >= word_t'(burst_len))
      stop_on_error("Words left over after the last packet exceed one burst.");
    check_word("reg_sum", sum, word_t'(full_sum) * packets + k * (k + 1) / 2);
  endtask

  task automatic test_reset_state();
    idle_cycles(start_count + 10); // Source is ready, sink still off.
    expect_reg("reg_ctrl", reg_ctrl, '0);
    expect_reg("reg_packets", reg_packets, '0);
    expect_reg("reg_words", reg_words, '0);
    expect_reg("reg_sum", reg_sum, '0);
    expect_reg("reg_last_len", reg_last_len, '0);
    expect_reg("reg_seq_err", reg_seq_err, '0);
  endtask

  task automatic test_ctrl_and_errors();
    word_t data;
    resp_t resp;
    write_reg("reg_ctrl", reg_ctrl, 32'h1, resp_okay);
    expect_reg("reg_ctrl", reg_ctrl, 32'h1);
    write_reg("reg_ctrl", reg_ctrl, 32'h0, resp_okay);
    write_reg("reg_sum", reg_sum, 32'hA5A5_0001, resp_slverr);
    expect_reg("reg_ctrl", reg_ctrl, 32'h0);
    lite_read(5'h18, data, resp);
    check_resp("addr 0x18", resp, resp_slverr);
    check_word("addr 0x18", data, '0);
  endtask

  task automatic test_accounting();
    write_reg("reg_ctrl", reg_ctrl, 32'h1, resp_okay);
    idle_cycles($urandom_range(220, 20));
    write_reg("reg_ctrl", reg_ctrl, 32'h0, resp_okay);
    idle_cycles(10);
    check_accounting();
  endtask

  task automatic test_last_len();
    word_t packets;
    write_reg("reg_ctrl", reg_ctrl, 32'h1, resp_okay);
    packets = '0;
    while (packets == '0) read_reg("reg_packets", reg_packets, packets);
    write_reg("reg_ctrl", reg_ctrl, 32'h0, resp_okay);
    expect_reg("reg_last_len", reg_last_len, word_t'(burst_len));
  endtask

  // Short and long stalls leave the FIFO partly full or full.
  task automatic test_order();
    repeat (12) begin
      write_reg("reg_ctrl", reg_ctrl, 32'h1, resp_okay);
      idle_cycles($urandom_range(30, 1));
      write_reg("reg_ctrl", reg_ctrl, 32'h0, resp_okay);
      idle_cycles($urandom_range(60, 1));
    end
    expect_reg("reg_seq_err", reg_seq_err, '0);
    check_accounting();
  endtask

  initial begin
    repeat (20 * total_budget) @(posedge M_AXIS_ACLK);
    $display("Timeout: the tests did not finish within the cycle budget.");
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired.");
  end

  initial begin
    void'($urandom(16));
    M_AXIS_ARESETN = 1'b0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr = '0;
    araddr = '0;
    wdata  = '0;
    idle_cycles(rst_cycles);
    M_AXIS_ARESETN = 1'b1;
    test_reset_state();
    idle_cycles($urandom_range(8, 1));
    test_ctrl_and_errors();
    idle_cycles($urandom_range(8, 1));
    test_accounting();
    idle_cycles($urandom_range(8, 1));
    test_last_len();
    idle_cycles($urandom_range(8, 1));
    test_order();
    if (i_dut.i_fifo.i_fifo_checks.violations == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* stream_burst.f */
hw/stream_burst_pkg.sv
hw/burst_source.sv
hw/stream_fifo.sv
hw/burst_sink.sv
hw/stream_burst_top.sv
tests/stream_burst_assertions.sv
tests/tb_stream_burst.sv

/* Bender.yml */
package:
  name: stream_burst

sources:
  - hw/stream_burst_pkg.sv
  - hw/burst_source.sv
  - hw/stream_fifo.sv
  - hw/burst_sink.sv
  - hw/stream_burst_top.sv
  - target: test
    files:
      - tests/stream_burst_assertions.sv
      - tests/tb_stream_burst.sv
